/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_rk_subsystem -f tb.f -o vtb_rk_subsystem

./obj_dir/vtb_rk_subsystem > sim.log 2>&1 || true
cat sim.log

if grep -q "All checks passed" sim.log; then
   exit 0
fi
exit 1

/* tb.f */
+incdir+verilog
verilog/rk_pkg.sv
verilog/rk_iopage_decode.sv
verilog/rk_controller.sv
verilog/ata_pio_port.sv
verilog/rk_dma_arbiter.sv
verilog/rk_subsystem.sv
verification/ide_drive_model.sv
verification/tb_rk_subsystem.sv

/* verification/ide_drive_model.sv */
`timescale 1ns/100ps
`include "rk_macros.svh"

module ide_drive_model
(
   input  logic             clk,
   input  logic [1:0]       cs_n,
   input  logic [2:0]       da,
   input  logic             dior_n,
   input  logic             diow_n,
   input  rk_pkg::rk_word_t host_data,
   output rk_pkg::rk_word_t drive_data,
   input  logic             inject_err
);

   rk_pkg::rk_word_t secnum = '0;
   rk_pkg::rk_word_t cyllow = '0;
   rk_pkg::rk_lba_t  lba = '0;
   logic             drq = 1'b0;
   logic             err = 1'b0;
   int               ptr = 0;
   // words written by the host, recorded for the testbench
   rk_pkg::rk_word_t wr_buf [0:1023];
   rk_pkg::rk_lba_t  wr_lba = '0;
   int               wr_count = 0;
   logic             wr_pend = 1'b0;
   logic             rd_pend = 1'b0;
   logic             rd_is_data = 1'b0;
   logic [1:0]       wr_cs = '0;
   logic [2:0]       wr_da = '0;
   rk_pkg::rk_word_t wr_data = '0;
   logic [7:0]       status;

   // sector word from the block address and the word index
   function automatic rk_pkg::rk_word_t sector_word(rk_pkg::rk_lba_t blk, int idx);
      rk_pkg::rk_lba_t b;
      b = blk + rk_pkg::rk_lba_t'(idx / 256);
      return b * 16'd257 + 16'((idx % 256) * 3) + 16'h5a5a;
   endfunction

   always_comb
   begin
      status = 8'h00;
      status[`ATA_ST_DRDY] = 1'b1;
      status[`ATA_ST_DRQ] = drq;
      status[`ATA_ST_ERR] = err;
      if (cs_n == 2'b10 && da == 3'd0)
         drive_data = sector_word(lba, ptr);
      else if ((cs_n == 2'b10 && da == 3'd7) || (cs_n == 2'b01 && da == 3'd6))
         drive_data = {8'h00, status};
      else
         drive_data = '0;
   end

   // a register access takes effect when its strobe goes back high
   always @(posedge clk)
   begin
      if (!diow_n)
      begin
         wr_pend <= 1'b1;
         wr_cs <= cs_n;
         wr_da <= da;
         wr_data <= host_data;
      end
      else if (wr_pend)
      begin
         wr_pend <= 1'b0;
         if (wr_cs == 2'b10)
         begin
            case (wr_da)
               3'd0:
               begin
                  wr_buf[wr_count % 1024] <= wr_data;
                  wr_count <= wr_count + 1;
               end
               3'd3: secnum <= wr_data;
               3'd4: cyllow <= wr_data;
               3'd7:
               begin
                  lba <= {cyllow[7:0], secnum[7:0]};
                  ptr <= 0;
                  err <= inject_err;
                  drq <= !inject_err;
                  if (wr_data == `ATA_CMD_WRITE)
                  begin
                     wr_lba <= {cyllow[7:0], secnum[7:0]};
                     wr_count <= 0;
                  end
               end
               default: ;
            endcase
         end
      end
      if (!dior_n)
      begin
         rd_pend <= 1'b1;
         rd_is_data <= (cs_n == 2'b10 && da == 3'd0);
      end
      else if (rd_pend)
      begin
         rd_pend <= 1'b0;
         if (rd_is_data)
            ptr <= ptr + 1;
      end
   end

endmodule

/* verification/tb_rk_subsystem.sv */
`timescale 1ns/100ps
`include "rk_macros.svh"

module tb_rk_subsystem;

   localparam int N = `RK_NUM_CTRL;

   logic                 clk = 1'b0;
   logic                 reset = 1'b1;
   rk_pkg::rk_iop_addr_t iop_addr = '0;
   rk_pkg::rk_word_t     iop_data_in = '0;
   logic                 iop_rd = 1'b0;
   logic                 iop_wr = 1'b0;
   logic                 iop_byte_op = 1'b0;
   rk_pkg::rk_word_t     iop_data_out;
   logic                 iop_decode;
   logic                 mem_req;
   rk_pkg::rk_bus_addr_t mem_addr;
   logic                 mem_we;
   rk_pkg::rk_word_t     mem_wdata;
   rk_pkg::rk_word_t     mem_rdata = '0;
   logic                 mem_ack = 1'b0;
   logic                 irq;
   logic [7:0]           irq_vector;
   logic                 irq_ack = 1'b0;
   logic [1:0]           ide_cs_n [N];
   logic [2:0]           ide_da [N];
   logic [N-1:0]         ide_dior_n;
   logic [N-1:0]         ide_diow_n;
   rk_pkg::rk_word_t     ide_data_out [N];
   logic [N-1:0]         ide_data_oe;
   rk_pkg::rk_word_t     ide_data_in [N];
   logic [N-1:0]         inject_err = '0;

   rk_pkg::rk_word_t     mem [0:131071];
   rk_pkg::rk_word_t     exp_words [0:63];
   int                   mem_wait = 0;
   int                   errors = 0;
   int                   checks = 0;
   logic                 timed_out = 1'b0;

   rk_subsystem u_rk_subsystem
   (
      .clk, .reset, .iop_addr, .iop_data_in, .iop_rd, .iop_wr, .iop_byte_op,
      .iop_data_out, .iop_decode, .mem_req, .mem_addr, .mem_we, .mem_wdata,
      .mem_rdata, .mem_ack, .irq, .irq_vector, .irq_ack, .ide_cs_n, .ide_da,
      .ide_dior_n, .ide_diow_n, .ide_data_out, .ide_data_oe, .ide_data_in
   );

   for (genvar k = 0; k < N; k++)
   begin : g_drive
      ide_drive_model u_drive
      (
         .clk, .cs_n(ide_cs_n[k]), .da(ide_da[k]), .dior_n(ide_dior_n[k]),
         .diow_n(ide_diow_n[k]), .host_data(ide_data_out[k]),
         .drive_data(ide_data_in[k]), .inject_err(inject_err[k])
      );
   end

   always #50 clk = ~clk;

   // memory acks after 0 to 3 idle cycles
   always @(negedge clk)
   begin
      if (mem_ack)
         mem_ack = 1'b0;
      else if (mem_req)
      begin
         if (mem_wait == 0)
         begin
            mem_rdata = mem[mem_addr[17:1]];
            if (mem_we)
               mem[mem_addr[17:1]] = mem_wdata;
            mem_ack = 1'b1;
            mem_wait = $urandom % 4;
         end
         else
            mem_wait--;
      end
   end

   function automatic rk_pkg::rk_word_t expected_word(rk_pkg::rk_lba_t lba, int i);
      rk_pkg::rk_lba_t blk;
      blk = lba + rk_pkg::rk_lba_t'(i / 256);
      return blk * 16'd257 + 16'((i % 256) * 3) + 16'h5a5a;
   endfunction

   function automatic rk_pkg::rk_iop_addr_t reg_addr(int k, int off);
      return `RK_IOP_BASE + 13'(k) * `RK_IOP_STRIDE + 13'(off);
   endfunction

   task automatic check(input logic ok, input string what);
      checks++;
      assert (ok)
      else
      begin
         errors++;
         $display("[FAIL] %0t %s", $time, what);
      end
   endtask

   task automatic end_run;
      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0)
         $display("All checks passed");
      else
         $display("Checks failed");
      $finish;
   endtask

   // the stuck sequence parks here while the run is closed elsewhere
   task automatic give_up(input string what);
      errors++;
      $display("timeout while waiting for %s", what);
      timed_out = 1'b1;
      forever @(negedge clk);
   endtask

   initial
   begin
      wait (timed_out);
      end_run();
   end

   task automatic iop_write(input rk_pkg::rk_iop_addr_t addr, input rk_pkg::rk_word_t data);
      @(negedge clk);
      iop_rd = 1'b0;
      iop_byte_op = 1'b0;
      iop_addr = addr;
      iop_data_in = data;
      iop_wr = 1'b1;
      @(negedge clk);
      iop_wr = 1'b0;
   endtask

   task automatic iop_read(input rk_pkg::rk_iop_addr_t addr, input logic byte_op,
                           output rk_pkg::rk_word_t data, output logic dec);
      @(negedge clk);
      iop_addr = addr;
      iop_byte_op = byte_op;
      iop_rd = 1'b1;
      #20;
      data = iop_data_out;
      dec = iop_decode;
   endtask

   task automatic start_cmd(input int k, input rk_pkg::rk_word_t da, input int count,
                            input rk_pkg::rk_word_t ba, input rk_pkg::rk_word_t cs);
      iop_write(reg_addr(k, 'o0), da);
      iop_write(reg_addr(k, 'o6), 16'(-count));
      iop_write(reg_addr(k, 'o10), ba);
      iop_write(reg_addr(k, 'o4), cs);
   endtask

   task automatic wait_done(input int k);
      rk_pkg::rk_word_t d;
      logic dec;
      for (int n = 0; n < 20000; n++)
      begin
         iop_read(reg_addr(k, 'o4), 1'b0, d, dec);
         if (d[7])
            return;
      end
      give_up($sformatf("done on controller %0d", k));
   endtask

   task automatic wait_irq;
      for (int n = 0; n < 20000; n++)
      begin
         @(negedge clk);
         if (irq)
            return;
      end
      give_up("irq");
   endtask

   task automatic ack_irq;
      @(negedge clk);
      irq_ack = 1'b1;
      @(negedge clk);
      irq_ack = 1'b0;
      check(!irq, "irq still high after ack");
   endtask

   task automatic check_read(input int k, input rk_pkg::rk_lba_t lba, input int count,
                             input rk_pkg::rk_word_t ba);
      rk_pkg::rk_word_t d;
      logic dec;
      for (int i = 0; i < count; i++)
         check(mem[(ba >> 1) + i] == expected_word(lba, i),
               $sformatf("ctrl %0d memory word %0d of lba %0d", k, i, lba));
      iop_read(reg_addr(k, 'o6), 1'b0, d, dec);
      check(d == 16'h0000, $sformatf("ctrl %0d wc not zero: %h", k, d));
      iop_read(reg_addr(k, 'o10), 1'b0, d, dec);
      check(d == ba + 16'(2 * count), $sformatf("ctrl %0d ba end %h", k, d));
   endtask

   initial
   begin
      rk_pkg::rk_word_t v;
      rk_pkg::rk_word_t d;
      rk_pkg::rk_word_t da_val;
      logic dec;
      void'($urandom(13760));
      repeat (16) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      check(!irq && !mem_req && &ide_dior_n && &ide_diow_n && ide_data_oe == '0,
            "outputs active after reset");

      // register access
      for (int k = 0; k < N; k++)
      begin
         iop_read(reg_addr(k, 'o4), 1'b0, d, dec);
         check(!d[15] && !d[7], $sformatf("ctrl %0d done or error after reset", k));
         // da, wc and ba at offsets 0, 6 and 010
         for (int i = 0; i < 3; i++)
         begin
            v = $urandom;
            iop_write(reg_addr(k, 2 * i + (i == 0 ? 0 : 4)), v);
            iop_read(reg_addr(k, 2 * i + (i == 0 ? 0 : 4)), 1'b0, d, dec);
            check(dec && d == v, $sformatf("ctrl %0d reg %0d readback %h", k, i, d));
            if (i == 0)
               da_val = v;
         end
         iop_read(reg_addr(k, 'o12), 1'b0, d, dec);
         check(dec && d == da_val, "da alias differs from da");
         v = $urandom & 16'hfffe;
         iop_write(reg_addr(k, 'o4), v);
         iop_read(reg_addr(k, 'o4), 1'b0, d, dec);
         check(d == (v & 16'h00ff), $sformatf("ctrl %0d cs readback %h", k, d));
         v = $urandom;
         iop_write(reg_addr(k, 'o10), v);
         iop_read(reg_addr(k, 'o10), 1'b1, d, dec);
         check(d == {8'h00, v[7:0]}, "low byte read");
         iop_read(reg_addr(k, 'o11), 1'b1, d, dec);
         check(d == {8'h00, v[15:8]}, "high byte read");
         iop_write(reg_addr(k, 'o4), 16'h0000);
      end
      iop_read(13'o17376, 1'b0, d, dec);
      check(!dec && d == 0, "decode below base");
      iop_read(13'o17440, 1'b0, d, dec);
      check(!dec && d == 0, "decode above windows");
      iop_read(13'o17414, 1'b0, d, dec);
      check(!dec && d == 0, "decode of unused offset");

      // read with IE on controller 0, track 5 sector 7
      start_cmd(0, 16'h0057, 20, 16'h1000, 16'h0045);
      wait_irq();
      check(irq_vector == `RK_VEC_BASE, $sformatf("vector %o", irq_vector));
      iop_read(reg_addr(0, 'o4), 1'b0, d, dec);
      check(d[7] && !d[0], "read done or go state");
      check_read(0, 16'd67, 20, 16'h1000);
      ack_irq();

      // write with IE clear on controller 1, track 1 sector 0
      for (int i = 0; i < 24; i++)
      begin
         exp_words[i] = $urandom;
         mem[(16'h6000 >> 1) + i] = exp_words[i];
      end
      start_cmd(1, 16'h0010, 24, 16'h6000, 16'h0003);
      wait_done(1);
      check(!irq, "irq raised with IE clear");
      check(g_drive[1].u_drive.wr_lba == 16'd12 && g_drive[1].u_drive.wr_count == 24,
            "write lba or word count");
      for (int i = 0; i < 24; i++)
         check(g_drive[1].u_drive.wr_buf[i] == exp_words[i],
               $sformatf("written word %0d", i));

      // concurrent reads, controller 0 crosses a sector boundary
      // controller 1 interrupts on its own vector
      start_cmd(0, 16'h003b, 300, 16'h4000, 16'h0005);
      start_cmd(1, 16'h00a2, 100, 16'h8000, 16'h0045);
      wait_done(0);
      wait_done(1);
      check(irq && irq_vector == `RK_VEC_BASE - 8'd4,
            $sformatf("ctrl 1 vector %o", irq_vector));
      ack_irq();
      check_read(0, 16'd47, 300, 16'h4000);
      check_read(1, 16'd122, 100, 16'h8000);

      // error path on controller 0
      inject_err[0] = 1'b1;
      start_cmd(0, 16'h0000, 8, 16'h2000, 16'h0005);
      wait_done(0);
      iop_read(reg_addr(0, 'o4), 1'b0, d, dec);
      check(d[15] && d[7], "error bit or done missing");
      inject_err[0] = 1'b0;
      iop_write(reg_addr(0, 'o4), 16'h0005);
      iop_read(reg_addr(0, 'o4), 1'b0, d, dec);
      check(!d[15], "error bit not cleared by go");
      wait_done(0);
      end_run();
   end

endmodule

/* verilog/ata_pio_port.sv */
`timescale 1ns/100ps
`include "rk_macros.svh"

module ata_pio_port
(
   input  logic             clk,
   input  logic             reset,
   input  logic             ata_rd,
   input  logic             ata_wr,
   input  logic [4:0]       ata_addr,
   input  rk_pkg::rk_word_t ata_wdata,
   output rk_pkg::rk_word_t ata_rdata,
   output logic             ata_done,
   output logic [1:0]       ide_cs_n,
   output logic [2:0]       ide_da,
   output logic             ide_dior_n,
   output logic             ide_diow_n,
   output rk_pkg::rk_word_t ide_data_out,
   output logic             ide_data_oe,
   input  rk_pkg::rk_word_t ide_data_in
);

   localparam int CW = $clog2(`RK_ATA_CYCLE) + 1;

   logic [CW-1:0] cnt;
   logic          active;
   logic          last;

   // the done clock is idle on the pins, so a held request starts a fresh cycle
   assign active = (ata_rd || ata_wr) && !ata_done;
   assign last = (cnt == CW'(`RK_ATA_CYCLE - 1));

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         cnt <= '0;
         ata_done <= 1'b0;
      end
      else
      begin
         ata_done <= active && last;
         if (!active || last)
            cnt <= '0;
         else
            cnt <= cnt + 1'b1;
      end
   end

   always_ff @(posedge clk)
      if (active && last && ata_rd)
         ata_rdata <= ide_data_in;

   // code bits 4:3 are already the active-low chip selects
   assign ide_cs_n = active ? ata_addr[4:3] : 2'b11;
   assign ide_da = active ? ata_addr[2:0] : 3'b000;
   assign ide_dior_n = !(active && ata_rd);
   assign ide_diow_n = !(active && ata_wr);
   assign ide_data_out = ata_wdata;
   assign ide_data_oe = active && ata_wr;

endmodule

/* verilog/rk_controller.sv */
`timescale 1ns/100ps
`include "rk_macros.svh"

module rk_controller
(
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  sel,
   input  rk_pkg::rk_reg_idx_t   reg_idx,
   input  logic                  iop_wr,
   input  rk_pkg::rk_word_t      iop_data_in,
   output rk_pkg::rk_word_t      rd_data,
   output logic                  ata_rd,
   output logic                  ata_wr,
   output logic [4:0]            ata_addr,
   output rk_pkg::rk_word_t      ata_wdata,
   input  rk_pkg::rk_word_t      ata_rdata,
   input  logic                  ata_done,
   output logic                  dma_req,
   output rk_pkg::rk_bus_addr_t  dma_addr,
   output logic                  dma_we,
   output rk_pkg::rk_word_t      dma_wdata,
   input  rk_pkg::rk_word_t      dma_rdata,
   input  logic                  dma_ack,
   output logic                  irq_req,
   input  logic                  irq_ack
);

   rk_pkg::rk_word_t      rkda;
   rk_pkg::rk_word_t      rker;
   rk_pkg::rk_word_t      rkwc;
   rk_pkg::rk_bus_addr_t  rkba;
   logic                  cs_err;
   logic                  cs_done;
   logic                  cs_ie;
   logic [3:0]            cs_cmd;
   rk_pkg::rk_lba_t       lba;
   logic [7:0]            sect_word;
   rk_pkg::rk_word_t      wr_hold;
   rk_pkg::rk_seq_state_t state;
   rk_pkg::rk_seq_state_t state_next;
   rk_pkg::rk_seq_state_t after_word;
   logic                  cpu_wr;
   logic                  is_read;
   logic                  is_write;
   logic                  inc_wc;
   logic                  inc_ba;
   logic                  set_err;
   logic                  finish;

   assign cpu_wr = iop_wr && sel;
   assign is_write = (cs_cmd[3:1] == 3'b001);
   assign is_read = (cs_cmd[3:1] == 3'b010);

   // rkda is {track[9:0], sector[3:0]}, twelve sectors per track
   assign lba = ({6'b0, rkda[13:4]} * 16'd12) + {12'b0, rkda[3:0]};

   always_comb
   begin
      case (reg_idx)
         3'd0, 3'd5: rd_data = rkda;
         3'd1:       rd_data = rker;
         3'd2:       rd_data = {cs_err, 7'b0, cs_done, cs_ie, rkba[17:16], cs_cmd};
         3'd3:       rd_data = rkwc;
         3'd4:       rd_data = rkba[15:0];
         default:    rd_data = '0;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         rkda <= '0;
         rker <= '0;
         rkwc <= '0;
         rkba <= '0;
         cs_err <= 1'b0;
         cs_done <= 1'b0;
         cs_ie <= 1'b0;
         cs_cmd <= '0;
      end
      else if (cpu_wr)
      begin
         case (reg_idx)
            3'd0, 3'd5: rkda <= iop_data_in;
            3'd2:
            begin
               // go drops the old error and done status
               if (iop_data_in[0])
               begin
                  cs_err <= 1'b0;
                  rker <= '0;
               end
               cs_done <= iop_data_in[7] && !iop_data_in[0];
               cs_ie <= iop_data_in[6];
               rkba[17:16] <= iop_data_in[5:4];
               cs_cmd <= iop_data_in[3:0];
            end
            3'd3: rkwc <= iop_data_in;
            3'd4: rkba[15:0] <= iop_data_in;
            default: ;
         endcase
      end
      else
      begin
         if (set_err)
         begin
            cs_err <= 1'b1;
            rker[15] <= 1'b1;
         end
         if (inc_wc)
            rkwc <= rkwc + 16'd1;
         if (inc_ba)
            rkba <= rkba + 18'd2;
         if (finish)
         begin
            cs_done <= 1'b1;
            cs_cmd[0] <= 1'b0;
         end
      end
   end

   // sect_word wraps at each 256-word drive sector
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state <= rk_pkg::idle;
         sect_word <= '0;
         irq_req <= 1'b0;
      end
      else
      begin
         state <= state_next;
         if (state == rk_pkg::idle)
            sect_word <= '0;
         else if (inc_wc)
            sect_word <= sect_word + 8'd1;
         if (finish && cs_ie)
            irq_req <= 1'b1;
         else if (irq_ack)
            irq_req <= 1'b0;
      end
   end

   always_ff @(posedge clk)
      if (state == rk_pkg::xfer_write_dma && dma_ack)
         wr_hold <= dma_rdata;

   assign dma_addr = rkba;
   assign dma_wdata = ata_rdata;

   // wc and sect_word already count the word just moved
   assign after_word = (rkwc == '0) ? rk_pkg::finish_status :
                       (sect_word == 8'd0) ? rk_pkg::poll_drq :
                       is_write ? rk_pkg::xfer_write_dma : rk_pkg::xfer_read_ide;

   always_comb
   begin
      case (state)
         rk_pkg::set_head:       ata_addr = `ATA_DRVHEAD;
         rk_pkg::set_count:      ata_addr = `ATA_SECCNT;
         rk_pkg::set_lba_lo:     ata_addr = `ATA_SECNUM;
         rk_pkg::set_lba_hi:     ata_addr = `ATA_CYLLOW;
         rk_pkg::set_cyl_hi:     ata_addr = `ATA_CYLHIGH;
         rk_pkg::issue_cmd:      ata_addr = `ATA_COMMAND;
         rk_pkg::poll_drq:       ata_addr = `ATA_DEVCTRL;
         rk_pkg::xfer_read_ide:  ata_addr = `ATA_DATA;
         rk_pkg::xfer_write_ide: ata_addr = `ATA_DATA;
         default:                ata_addr = `ATA_STATUS;
      endcase
      case (state)
         // lba mode, drive 0
         rk_pkg::set_head:   ata_wdata = 16'h0040;
         rk_pkg::set_count:  ata_wdata = {8'h00, ~rkwc[15:8] + 8'd1};
         rk_pkg::set_lba_lo: ata_wdata = {8'h00, lba[7:0]};
         rk_pkg::set_lba_hi: ata_wdata = {8'h00, lba[15:8]};
         rk_pkg::set_cyl_hi: ata_wdata = '0;
         rk_pkg::issue_cmd:  ata_wdata = is_write ? `ATA_CMD_WRITE : `ATA_CMD_READ;
         default:            ata_wdata = wr_hold;
      endcase
   end

   always_comb
   begin
      state_next = state;
      ata_rd = 1'b0;
      ata_wr = 1'b0;
      dma_req = 1'b0;
      dma_we = 1'b0;
      inc_wc = 1'b0;
      inc_ba = 1'b0;
      set_err = 1'b0;
      finish = 1'b0;
      case (state)
         rk_pkg::idle:
         begin
            // functions other than read and write complete at once
            if (cs_cmd[0])
               state_next = (is_read || is_write) ? rk_pkg::wait_ready : rk_pkg::finish_done;
         end
         rk_pkg::wait_ready:
         begin
            ata_rd = 1'b1;
            if (ata_done && !ata_rdata[`ATA_ST_BSY] && ata_rdata[`ATA_ST_DRDY])
               state_next = rk_pkg::set_head;
         end
         rk_pkg::set_head, rk_pkg::set_count, rk_pkg::set_lba_lo,
         rk_pkg::set_lba_hi, rk_pkg::set_cyl_hi, rk_pkg::issue_cmd:
         begin
            ata_wr = 1'b1;
            if (ata_done)
               state_next = state.next();
         end
         rk_pkg::poll_drq:
         begin
            ata_rd = 1'b1;
            if (ata_done && ata_rdata[`ATA_ST_ERR])
            begin
               set_err = 1'b1;
               state_next = rk_pkg::finish_status;
            end
            else if (ata_done && !ata_rdata[`ATA_ST_BSY] && ata_rdata[`ATA_ST_DRQ])
               state_next = is_write ? rk_pkg::xfer_write_dma : rk_pkg::xfer_read_ide;
         end
         rk_pkg::xfer_read_ide:
         begin
            ata_rd = 1'b1;
            inc_wc = ata_done;
            if (ata_done)
               state_next = rk_pkg::xfer_read_dma;
         end
         rk_pkg::xfer_read_dma:
         begin
            dma_req = 1'b1;
            dma_we = 1'b1;
            inc_ba = dma_ack;
            if (dma_ack)
               state_next = after_word;
         end
         rk_pkg::xfer_write_dma:
         begin
            dma_req = 1'b1;
            inc_wc = dma_ack;
            if (dma_ack)
               state_next = rk_pkg::xfer_write_ide;
         end
         rk_pkg::xfer_write_ide:
         begin
            ata_wr = 1'b1;
            inc_ba = ata_done;
            if (ata_done)
               state_next = after_word;
         end
         rk_pkg::finish_status:
         begin
            // status read also clears the drive's pending interrupt
            ata_rd = 1'b1;
            if (ata_done)
               state_next = rk_pkg::finish_done;
         end
         rk_pkg::finish_done:
         begin
            finish = 1'b1;
            state_next = rk_pkg::idle;
         end
         default:
            state_next = rk_pkg::idle;
      endcase
   end

endmodule

/* verilog/rk_dma_arbiter.sv */
`timescale 1ns/100ps
`include "rk_macros.svh"

module rk_dma_arbiter
(
   input  logic                     clk,
   input  logic                     reset,
   input  logic [`RK_NUM_CTRL-1:0]  dma_req,
   input  rk_pkg::rk_bus_addr_t     dma_addr [`RK_NUM_CTRL],
   input  logic [`RK_NUM_CTRL-1:0]  dma_we,
   input  rk_pkg::rk_word_t         dma_wdata [`RK_NUM_CTRL],
   output logic [`RK_NUM_CTRL-1:0]  dma_ack,
   output rk_pkg::rk_word_t         dma_rdata,
   output logic                     mem_req,
   output rk_pkg::rk_bus_addr_t     mem_addr,
   output logic                     mem_we,
   output rk_pkg::rk_word_t         mem_wdata,
   input  rk_pkg::rk_word_t         mem_rdata,
   input  logic                     mem_ack,
   input  logic [`RK_NUM_CTRL-1:0]  irq_req,
   output logic [`RK_NUM_CTRL-1:0]  irq_ack,
   output logic                     irq,
   output logic [7:0]               irq_vector,
   input  logic                     irq_ack_cpu
);

   localparam int N = `RK_NUM_CTRL;
   localparam int IW = (N > 1) ? $clog2(N) : 1;

   logic          busy;
   logic [IW-1:0] grant;
   logic [IW-1:0] rr_ptr;
   logic [IW-1:0] pick;
   logic          pick_valid;
   logic [IW-1:0] irq_idx;

   // nearest requester at or after the rotating pointer
   always_comb
   begin
      int idx;
      pick = '0;
      pick_valid = 1'b0;
      for (int i = N - 1; i >= 0; i--)
      begin
         idx = (int'(rr_ptr) + i) % N;
         if (dma_req[idx])
         begin
            pick = IW'(idx);
            pick_valid = 1'b1;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         busy <= 1'b0;
         grant <= '0;
         rr_ptr <= '0;
      end
      else if (!busy && pick_valid)
      begin
         busy <= 1'b1;
         grant <= pick;
      end
      else if (busy && mem_ack)
      begin
         busy <= 1'b0;
         rr_ptr <= IW'((int'(grant) + 1) % N);
      end
   end

   assign mem_req = busy;
   assign mem_addr = dma_addr[grant];
   assign mem_we = dma_we[grant];
   assign mem_wdata = dma_wdata[grant];
   assign dma_rdata = mem_rdata;
   assign dma_ack = (busy && mem_ack) ? (N'(1) << grant) : '0;

   // lowest index wins the interrupt line
   always_comb
   begin
      irq_idx = '0;
      for (int i = N - 1; i >= 0; i--)
         if (irq_req[i])
            irq_idx = IW'(i);
   end

   assign irq = |irq_req;
   assign irq_vector = `RK_VEC_BASE - {irq_idx, 2'b00};
   assign irq_ack = (irq_ack_cpu && irq) ? (N'(1) << irq_idx) : '0;

endmodule

/* verilog/rk_iopage_decode.sv */
`timescale 1ns/100ps
`include "rk_macros.svh"

module rk_iopage_decode
(
   input  rk_pkg::rk_iop_addr_t      iop_addr,
   input  logic                      iop_byte_op,
   input  logic                      iop_rd,
   input  rk_pkg::rk_word_t          ctrl_rd_data [`RK_NUM_CTRL],
   output logic [`RK_NUM_CTRL-1:0]   ctrl_sel,
   output rk_pkg::rk_reg_idx_t       reg_idx,
   output logic                      byte_hi,
   output rk_pkg::rk_word_t          iop_data_out,
   output logic                      iop_decode
);

   rk_pkg::rk_iop_addr_t offset;
   rk_pkg::rk_iop_addr_t reg_off;
   rk_pkg::rk_word_t     sel_word;

   // addresses below the base wrap high and miss every window
   assign offset = iop_addr - `RK_IOP_BASE;
   assign reg_off = offset % `RK_IOP_STRIDE;
   assign reg_idx = rk_pkg::rk_reg_idx_t'(reg_off >> 1);
   assign byte_hi = iop_addr[0];

   // only offsets 0 to 012 hold registers
   always_comb
   begin
      ctrl_sel = '0;
      for (int k = 0; k < `RK_NUM_CTRL; k++)
         if ((offset / `RK_IOP_STRIDE) == k && reg_idx <= 3'd5)
            ctrl_sel[k] = 1'b1;
   end

   always_comb
   begin
      sel_word = '0;
      for (int k = 0; k < `RK_NUM_CTRL; k++)
         if (ctrl_sel[k])
            sel_word = ctrl_rd_data[k];
   end

   assign iop_decode = |ctrl_sel;

   // byte reads return the addressed lane in the low byte
   always_comb
   begin
      if (!(iop_rd && iop_decode))
         iop_data_out = '0;
      else if (iop_byte_op)
         iop_data_out = {8'h00, byte_hi ? sel_word[15:8] : sel_word[7:0]};
      else
         iop_data_out = sel_word;
   end

endmodule

/* verilog/rk_macros.svh */
`ifndef RK_MACROS_SVH
`define RK_MACROS_SVH

`define RK_NUM_CTRL    2
`define RK_IOP_BASE    13'o17400
`define RK_IOP_STRIDE  13'o20
`define RK_VEC_BASE    8'o220
`define RK_ATA_CYCLE   4

// ata register codes, {cs1_n, cs0_n, da}
// alternate status reads back through the devctrl code
`define ATA_DEVCTRL    5'b01110
`define ATA_DATA       5'b10000
`define ATA_SECCNT     5'b10010
`define ATA_SECNUM     5'b10011
`define ATA_CYLLOW     5'b10100
`define ATA_CYLHIGH    5'b10101
`define ATA_DRVHEAD    5'b10110
`define ATA_STATUS     5'b10111
`define ATA_COMMAND    5'b10111

`define ATA_ST_BSY     7
`define ATA_ST_DRDY    6
`define ATA_ST_DRQ     3
`define ATA_ST_ERR     0

`define ATA_CMD_READ   16'h0020
`define ATA_CMD_WRITE  16'h0030

`endif

/* verilog/rk_pkg.sv */
package rk_pkg;

   typedef logic [15:0] rk_word_t;
   // {mex, rkba} byte address on the memory side
   typedef logic [17:0] rk_bus_addr_t;
   typedef logic [12:0] rk_iop_addr_t;
   typedef logic [15:0] rk_lba_t;
   // 0 da, 1 er, 2 cs, 3 wc, 4 ba, 5 da alias
   typedef logic [2:0]  rk_reg_idx_t;

   typedef enum logic [3:0]
   {
      idle,
      wait_ready,
      set_head,
      set_count,
      set_lba_lo,
      set_lba_hi,
      set_cyl_hi,
      issue_cmd,
      poll_drq,
      xfer_read_ide,
      xfer_read_dma,
      xfer_write_dma,
      xfer_write_ide,
      finish_status,
      finish_done
   } rk_seq_state_t;

endpackage

/* verilog/rk_subsystem.sv */
`timescale 1ns/100ps
`include "rk_macros.svh"

module rk_subsystem
(
   input  logic                     clk,
   input  logic                     reset,
   input  rk_pkg::rk_iop_addr_t     iop_addr,
   input  rk_pkg::rk_word_t         iop_data_in,
   input  logic                     iop_rd,
   input  logic                     iop_wr,
   input  logic                     iop_byte_op,
   output rk_pkg::rk_word_t         iop_data_out,
   output logic                     iop_decode,
   output logic                     mem_req,
   output rk_pkg::rk_bus_addr_t     mem_addr,
   output logic                     mem_we,
   output rk_pkg::rk_word_t         mem_wdata,
   input  rk_pkg::rk_word_t         mem_rdata,
   input  logic                     mem_ack,
   output logic                     irq,
   output logic [7:0]               irq_vector,
   input  logic                     irq_ack,
   output logic [1:0]               ide_cs_n [`RK_NUM_CTRL],
   output logic [2:0]               ide_da [`RK_NUM_CTRL],
   output logic [`RK_NUM_CTRL-1:0]  ide_dior_n,
   output logic [`RK_NUM_CTRL-1:0]  ide_diow_n,
   output rk_pkg::rk_word_t         ide_data_out [`RK_NUM_CTRL],
   output logic [`RK_NUM_CTRL-1:0]  ide_data_oe,
   input  rk_pkg::rk_word_t         ide_data_in [`RK_NUM_CTRL]
);

   logic [`RK_NUM_CTRL-1:0] ctrl_sel;
   rk_pkg::rk_reg_idx_t     reg_idx;
   logic                    byte_hi;
   rk_pkg::rk_word_t        wr_data;
   rk_pkg::rk_word_t        ctrl_rd_data [`RK_NUM_CTRL];
   logic [`RK_NUM_CTRL-1:0] dma_req;
   logic [`RK_NUM_CTRL-1:0] dma_we;
   logic [`RK_NUM_CTRL-1:0] dma_ack;
   rk_pkg::rk_bus_addr_t    dma_addr [`RK_NUM_CTRL];
   rk_pkg::rk_word_t        dma_wdata [`RK_NUM_CTRL];
   rk_pkg::rk_word_t        dma_rdata;
   logic [`RK_NUM_CTRL-1:0] irq_req;
   logic [`RK_NUM_CTRL-1:0] ctrl_irq_ack;

   // a high byte write lands in the low lane of the register
   assign wr_data = (iop_byte_op && byte_hi) ? {8'h00, iop_data_in[15:8]} : iop_data_in;

   rk_iopage_decode u_decode
   (
      .iop_addr, .iop_byte_op, .iop_rd, .ctrl_rd_data,
      .ctrl_sel, .reg_idx, .byte_hi, .iop_data_out, .iop_decode
   );

   for (genvar k = 0; k < `RK_NUM_CTRL; k++)
   begin : g_ctrl
      logic             ata_rd;
      logic             ata_wr;
      logic [4:0]       ata_addr;
      rk_pkg::rk_word_t ata_wdata;
      rk_pkg::rk_word_t ata_rdata;
      logic             ata_done;

      rk_controller u_ctrl
      (
         .clk, .reset, .sel(ctrl_sel[k]), .reg_idx, .iop_wr, .iop_data_in(wr_data),
         .rd_data(ctrl_rd_data[k]),
         .ata_rd, .ata_wr, .ata_addr, .ata_wdata, .ata_rdata, .ata_done,
         .dma_req(dma_req[k]), .dma_addr(dma_addr[k]), .dma_we(dma_we[k]),
         .dma_wdata(dma_wdata[k]), .dma_rdata, .dma_ack(dma_ack[k]),
         .irq_req(irq_req[k]), .irq_ack(ctrl_irq_ack[k])
      );

      ata_pio_port u_pio
      (
         .clk, .reset, .ata_rd, .ata_wr, .ata_addr, .ata_wdata, .ata_rdata, .ata_done,
         .ide_cs_n(ide_cs_n[k]), .ide_da(ide_da[k]),
         .ide_dior_n(ide_dior_n[k]), .ide_diow_n(ide_diow_n[k]),
         .ide_data_out(ide_data_out[k]), .ide_data_oe(ide_data_oe[k]),
         .ide_data_in(ide_data_in[k])
      );
   end

   rk_dma_arbiter u_arbiter
   (
      .clk, .reset, .dma_req, .dma_addr, .dma_we, .dma_wdata, .dma_ack, .dma_rdata,
      .mem_req, .mem_addr, .mem_we, .mem_wdata, .mem_rdata, .mem_ack,
      .irq_req, .irq_ack(ctrl_irq_ack), .irq, .irq_vector, .irq_ack_cpu(irq_ack)
   );

endmodule
